// ==== hw/mcu_defs.svh ====
`ifndef MCU_DEFS_SVH
`define MCU_DEFS_SVH

// ========================================================================
// core data path
// ========================================================================

`define MCU_XLEN 32

// reset value of mtvec
`define MTVEC_RESET 32'h8000_0100

// ========================================================================
// interrupt controller sizing
// ========================================================================

// source 0 is reserved, never pends
`define PLIC_NUM_SRC 8
`define PLIC_PRIO_W 3
`define PLIC_ID_W 3

`endif

// ==== hw/trap_pkg.sv ====
`include "mcu_defs.svh"

package trap_pkg;

    // machine mode csr addresses
    typedef enum logic [11:0] {
        CSR_MSTATUS = 12'h300,
        CSR_MIE     = 12'h304,
        CSR_MTVEC   = 12'h305,
        CSR_MEPC    = 12'h341,
        CSR_MCAUSE  = 12'h342,
        CSR_MIP     = 12'h344
    } csr_addr_e;

    // mcause values, msb marks an interrupt
    typedef enum logic [`MCU_XLEN-1:0] {
        CAUSE_ECALL_M = 32'h0000_000B,
        CAUSE_EXT_IRQ = 32'h8000_000B
    } trap_cause_e;

    typedef enum logic {
        IDLE    = 1'b0,
        IN_TRAP = 1'b1
    } trap_state_e;

endpackage

// ==== hw/plic_pkg.sv ====
package plic_pkg;

    typedef logic [23:0] plic_addr_t;

    // register map bases
    // priority region holds one word per id, id n at 4*n
    typedef enum plic_addr_t {
        PLIC_PRIO_BASE = 24'h00_0000,
        PLIC_PENDING   = 24'h00_1000,
        PLIC_ENABLE    = 24'h00_2000,
        PLIC_THRESHOLD = 24'h20_0000,
        PLIC_CLAIM     = 24'h20_0004
    } plic_reg_e;

endpackage

// ==== hw/trap_if.sv ====
`timescale 1ns/100ps

interface trap_if;

    // status seen by the trap controller
    logic                  mstatus_mie;
    logic                  mstatus_mpie;
    logic                  mie_meie;
    logic                  mip_meip;

    // one-cycle strobes towards the csr file
    logic                  trap_take;
    trap_pkg::trap_cause_e trap_cause;
    logic                  mret_take;

    modport csr (
        output mstatus_mie, mstatus_mpie, mie_meie, mip_meip,
        input  trap_take, trap_cause, mret_take
    );

    modport ctrl (
        input  mstatus_mie, mstatus_mpie, mie_meie, mip_meip,
        output trap_take, trap_cause, mret_take
    );

endinterface

// ==== hw/plic_gw_if.sv ====
`timescale 1ns/100ps
`include "mcu_defs.svh"

interface plic_gw_if;

    logic [`PLIC_NUM_SRC-1:0] pending;

    logic                     claim_stb;
    logic [`PLIC_ID_W-1:0]    claim_id;
    logic                     complete_stb;
    logic [`PLIC_ID_W-1:0]    complete_id;

    modport gw (
        output pending,
        input  claim_stb, claim_id, complete_stb, complete_id
    );

    modport arb (
        input  pending,
        output claim_stb, claim_id, complete_stb, complete_id
    );

endinterface

// ==== hw/plic_gateway.sv ====
`timescale 1ns/100ps
`include "mcu_defs.svh"

module plic_gateway (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic [`PLIC_NUM_SRC-1:0] intr_i,
    plic_gw_if.gw                    gw
);

    logic [`PLIC_NUM_SRC-1:0] pending_q;
    logic [`PLIC_NUM_SRC-1:0] in_service_q;

    // bit 0 is reserved and stays clear
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pending_q    <= '0;
            in_service_q <= '0;
        end else begin
            for (int i = 1; i < `PLIC_NUM_SRC; i++) begin
                if (gw.claim_stb && gw.claim_id == i) begin
                    pending_q[i]    <= 1'b0;
                    in_service_q[i] <= 1'b1;
                end else if (intr_i[i] && !pending_q[i] && !in_service_q[i]) begin
                    pending_q[i] <= 1'b1;
                end
                // complete reopens the gate for this source
                if (gw.complete_stb && gw.complete_id == i) begin
                    in_service_q[i] <= 1'b0;
                end
            end
        end
    end

    assign gw.pending = pending_q;

endmodule

// ==== hw/plic_arbiter.sv ====
`timescale 1ns/100ps
`include "mcu_defs.svh"

module plic_arbiter (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  plic_wen_i,
    input  logic                  plic_ren_i,
    input  plic_pkg::plic_addr_t  plic_addr_i,
    input  logic [`MCU_XLEN-1:0]  plic_wdata_i,
    output logic [`MCU_XLEN-1:0]  plic_rdata_o,
    output logic                  ext_pending_o,
    plic_gw_if.arb                gw
);

    logic [`PLIC_PRIO_W-1:0]  prio_q [1:`PLIC_NUM_SRC-1];
    logic [`PLIC_NUM_SRC-1:0] enable_q;
    logic [`PLIC_PRIO_W-1:0]  threshold_q;

    logic                     prio_sel;
    logic [`PLIC_ID_W-1:0]    prio_idx;
    logic                     claim_sel;
    logic [`PLIC_ID_W-1:0]    best_id;
    logic [`PLIC_PRIO_W-1:0]  best_prio;

    assign prio_sel  = (plic_addr_i[23:`PLIC_ID_W+2] == '0);
    assign prio_idx  = plic_addr_i[`PLIC_ID_W+1:2];
    assign claim_sel = (plic_addr_i == plic_pkg::PLIC_CLAIM);

    // ====================================================================
    // register writes
    // ====================================================================

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 1; i < `PLIC_NUM_SRC; i++) begin
                prio_q[i] <= '0;
            end
            enable_q    <= '0;
            threshold_q <= '0;
        end else if (plic_wen_i) begin
            for (int i = 1; i < `PLIC_NUM_SRC; i++) begin
                if (prio_sel && prio_idx == i) begin
                    prio_q[i] <= plic_wdata_i[`PLIC_PRIO_W-1:0];
                end
            end
            if (plic_addr_i == plic_pkg::PLIC_ENABLE) begin
                enable_q <= {plic_wdata_i[`PLIC_NUM_SRC-1:1], 1'b0};
            end
            if (plic_addr_i == plic_pkg::PLIC_THRESHOLD) begin
                threshold_q <= plic_wdata_i[`PLIC_PRIO_W-1:0];
            end
        end
    end

    // ====================================================================
    // winner selection
    // ====================================================================

    // strict compare keeps the lowest id on a tie
    always_comb begin
        best_id   = '0;
        best_prio = '0;
        for (int i = 1; i < `PLIC_NUM_SRC; i++) begin
            if (gw.pending[i] && enable_q[i] && prio_q[i] > best_prio) begin
                best_prio = prio_q[i];
                best_id   = i[`PLIC_ID_W-1:0];
            end
        end
    end

    assign ext_pending_o = (best_prio > threshold_q);

    // claim/complete
    assign gw.claim_id     = ext_pending_o ? best_id : '0;
    assign gw.claim_stb    = plic_ren_i && claim_sel && (gw.claim_id != '0);
    assign gw.complete_stb = plic_wen_i && claim_sel;
    assign gw.complete_id  = plic_wdata_i[`PLIC_ID_W-1:0];

    always_comb begin
        plic_rdata_o = '0;
        if (prio_sel) begin
            for (int i = 1; i < `PLIC_NUM_SRC; i++) begin
                if (prio_idx == i) begin
                    plic_rdata_o[`PLIC_PRIO_W-1:0] = prio_q[i];
                end
            end
        end else begin
            case (plic_addr_i)
                plic_pkg::PLIC_PENDING:   plic_rdata_o[`PLIC_NUM_SRC-1:0] = gw.pending;
                plic_pkg::PLIC_ENABLE:    plic_rdata_o[`PLIC_NUM_SRC-1:0] = enable_q;
                plic_pkg::PLIC_THRESHOLD: plic_rdata_o[`PLIC_PRIO_W-1:0] = threshold_q;
                plic_pkg::PLIC_CLAIM:     plic_rdata_o[`PLIC_ID_W-1:0] = gw.claim_id;
                default:                  plic_rdata_o = '0;
            endcase
        end
    end

endmodule

// ==== hw/csr_file.sv ====
`timescale 1ns/100ps
`include "mcu_defs.svh"

module csr_file (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 csr_wen_i,
    input  logic [11:0]          csr_addr_i,
    input  logic [`MCU_XLEN-1:0] csr_wdata_i,
    output logic [`MCU_XLEN-1:0] csr_rdata_o,
    input  logic [`MCU_XLEN-1:0] pc_i,
    input  logic                 ext_pending_i,
    output logic [`MCU_XLEN-1:0] trap_vector_o,
    output logic [`MCU_XLEN-1:0] epc_o,
    output logic [`MCU_XLEN-1:0] trap_cause_o,
    trap_if.csr                  ti
);

    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;
    localparam int MEI_BIT  = 11;

    logic [`MCU_XLEN-1:0] mstatus_q;
    logic [`MCU_XLEN-1:0] mie_q;
    logic [`MCU_XLEN-1:0] mtvec_q;
    logic [`MCU_XLEN-1:0] mepc_q;
    logic [`MCU_XLEN-1:0] mcause_q;
    logic [`MCU_XLEN-1:0] mip_val;
    trap_pkg::csr_addr_e  addr;

    assign addr = trap_pkg::csr_addr_e'(csr_addr_i);

    // mip is a live view of the controller line
    always_comb begin
        mip_val          = '0;
        mip_val[MEI_BIT] = ext_pending_i;
    end

    // ====================================================================
    // csr updates, trap entry overrides a software write
    // ====================================================================

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mstatus_q <= '0;
            mie_q     <= '0;
            mtvec_q   <= `MTVEC_RESET;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else begin
            if (csr_wen_i) begin
                case (addr)
                    trap_pkg::CSR_MSTATUS: mstatus_q <= csr_wdata_i;
                    trap_pkg::CSR_MIE:     mie_q     <= csr_wdata_i;
                    trap_pkg::CSR_MTVEC:   mtvec_q   <= csr_wdata_i;
                    trap_pkg::CSR_MEPC:    mepc_q    <= csr_wdata_i;
                    trap_pkg::CSR_MCAUSE:  mcause_q  <= csr_wdata_i;
                    default: ;
                endcase
            end
            if (ti.mret_take) begin
                mstatus_q[MIE_BIT]  <= mstatus_q[MPIE_BIT];
                mstatus_q[MPIE_BIT] <= 1'b1;
            end
            if (ti.trap_take) begin
                mepc_q              <= pc_i;
                mcause_q            <= ti.trap_cause;
                mstatus_q[MPIE_BIT] <= mstatus_q[MIE_BIT];
                mstatus_q[MIE_BIT]  <= 1'b0;
            end
        end
    end

    always_comb begin
        case (addr)
            trap_pkg::CSR_MSTATUS: csr_rdata_o = mstatus_q;
            trap_pkg::CSR_MIE:     csr_rdata_o = mie_q;
            trap_pkg::CSR_MTVEC:   csr_rdata_o = mtvec_q;
            trap_pkg::CSR_MEPC:    csr_rdata_o = mepc_q;
            trap_pkg::CSR_MCAUSE:  csr_rdata_o = mcause_q;
            trap_pkg::CSR_MIP:     csr_rdata_o = mip_val;
            default:               csr_rdata_o = '0;
        endcase
    end

    assign trap_vector_o = mtvec_q;
    assign epc_o         = mepc_q;
    assign trap_cause_o  = mcause_q;

    assign ti.mstatus_mie  = mstatus_q[MIE_BIT];
    assign ti.mstatus_mpie = mstatus_q[MPIE_BIT];
    assign ti.mie_meie     = mie_q[MEI_BIT];
    assign ti.mip_meip     = mip_val[MEI_BIT];

endmodule

// ==== hw/trap_ctrl.sv ====
`timescale 1ns/100ps
`include "mcu_defs.svh"

module trap_ctrl (
    input  logic clk,
    input  logic resetn,
    input  logic ecall_i,
    input  logic mret_i,
    output logic trap_flush_o,
    trap_if.ctrl ti
);

    trap_pkg::trap_state_e state_q;
    trap_pkg::trap_state_e state_d;
    logic                  irq_ready;

    // global enable, local enable and a line above threshold
    assign irq_ready = ti.mstatus_mie && ti.mie_meie && ti.mip_meip;

    always_comb begin
        state_d       = state_q;
        ti.trap_take  = 1'b0;
        ti.trap_cause = trap_pkg::CAUSE_ECALL_M;
        ti.mret_take  = 1'b0;
        case (state_q)
            trap_pkg::IDLE: begin
                // ecall wins over a concurrent interrupt
                if (ecall_i || irq_ready) begin
                    ti.trap_take = 1'b1;
                    if (ecall_i) begin
                        ti.trap_cause = trap_pkg::CAUSE_ECALL_M;
                    end else begin
                        ti.trap_cause = trap_pkg::CAUSE_EXT_IRQ;
                    end
                    state_d = trap_pkg::IN_TRAP;
                end
            end
            trap_pkg::IN_TRAP: begin
                if (mret_i) begin
                    ti.mret_take = 1'b1;
                    state_d      = trap_pkg::IDLE;
                end
            end
            default: state_d = trap_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q      <= trap_pkg::IDLE;
            trap_flush_o <= 1'b0;
        end else begin
            state_q      <= state_d;
            trap_flush_o <= ti.trap_take;
        end
    end

endmodule

// ==== hw/trap_unit_top.sv ====
`timescale 1ns/100ps
`include "mcu_defs.svh"

module trap_unit_top (
    input  logic                     clk,
    input  logic                     resetn,
    // core side csr port
    input  logic                     csr_wen_i,
    input  logic [11:0]              csr_addr_i,
    input  logic [`MCU_XLEN-1:0]     csr_wdata_i,
    output logic [`MCU_XLEN-1:0]     csr_rdata_o,
    input  logic                     ecall_i,
    input  logic                     mret_i,
    input  logic [`MCU_XLEN-1:0]     pc_i,
    // interrupt controller register bus
    input  logic                     plic_wen_i,
    input  logic                     plic_ren_i,
    input  plic_pkg::plic_addr_t     plic_addr_i,
    input  logic [`MCU_XLEN-1:0]     plic_wdata_i,
    output logic [`MCU_XLEN-1:0]     plic_rdata_o,
    input  logic [`PLIC_NUM_SRC-1:0] intr_i,
    // trap outputs
    output logic                     trap_flush_o,
    output logic [`MCU_XLEN-1:0]     trap_vector_o,
    output logic [`MCU_XLEN-1:0]     epc_o,
    output logic [`MCU_XLEN-1:0]     trap_cause_o
);

    logic ext_pending;

    trap_if    u_trap_if ();
    plic_gw_if u_gw_if ();

    plic_gateway u_plic_gateway (
        .clk    (clk),
        .resetn (resetn),
        .intr_i (intr_i),
        .gw     (u_gw_if.gw)
    );

    plic_arbiter u_plic_arbiter (
        .clk           (clk),
        .resetn        (resetn),
        .plic_wen_i    (plic_wen_i),
        .plic_ren_i    (plic_ren_i),
        .plic_addr_i   (plic_addr_i),
        .plic_wdata_i  (plic_wdata_i),
        .plic_rdata_o  (plic_rdata_o),
        .ext_pending_o (ext_pending),
        .gw            (u_gw_if.arb)
    );

    csr_file u_csr_file (
        .clk           (clk),
        .resetn        (resetn),
        .csr_wen_i     (csr_wen_i),
        .csr_addr_i    (csr_addr_i),
        .csr_wdata_i   (csr_wdata_i),
        .csr_rdata_o   (csr_rdata_o),
        .pc_i          (pc_i),
        .ext_pending_i (ext_pending),
        .trap_vector_o (trap_vector_o),
        .epc_o         (epc_o),
        .trap_cause_o  (trap_cause_o),
        .ti            (u_trap_if.csr)
    );

    trap_ctrl u_trap_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .ecall_i      (ecall_i),
        .mret_i       (mret_i),
        .trap_flush_o (trap_flush_o),
        .ti           (u_trap_if.ctrl)
    );

endmodule

// ==== dv/tb_trap_unit.sv ====
`timescale 1ns/100ps
`include "mcu_defs.svh"

module tb_trap_unit;

    typedef enum logic [3:0] {
        OP_CSR_WR,
        OP_CSR_RD,
        OP_PLIC_WR,
        OP_PLIC_RD,
        OP_ECALL,
        OP_MRET,
        OP_SRC,
        OP_IDLE,
        OP_CHK_FLUSH,
        OP_CHK_EPC,
        OP_CHK_CAUSE,
        OP_CHK_VEC
    } op_e;

    localparam int MAX_ROWS = 128;

    logic                     clk;
    logic                     resetn;
    logic                     csr_wen_i;
    logic [11:0]              csr_addr_i;
    logic [`MCU_XLEN-1:0]     csr_wdata_i;
    logic [`MCU_XLEN-1:0]     csr_rdata_o;
    logic                     ecall_i;
    logic                     mret_i;
    logic [`MCU_XLEN-1:0]     pc_i;
    logic                     plic_wen_i;
    logic                     plic_ren_i;
    plic_pkg::plic_addr_t     plic_addr_i;
    logic [`MCU_XLEN-1:0]     plic_wdata_i;
    logic [`MCU_XLEN-1:0]     plic_rdata_o;
    logic [`PLIC_NUM_SRC-1:0] intr_i;
    logic                     trap_flush_o;
    logic [`MCU_XLEN-1:0]     trap_vector_o;
    logic [`MCU_XLEN-1:0]     epc_o;
    logic [`MCU_XLEN-1:0]     trap_cause_o;

    op_e         row_op   [MAX_ROWS];
    logic [31:0] row_addr [MAX_ROWS];
    logic [31:0] row_data [MAX_ROWS];
    logic [31:0] row_exp  [MAX_ROWS];
    int          n_rows;
    int          error_count;
    int          cycle_count;
    int          cycle_limit;
    logic [31:0] vec1;
    logic [31:0] pc1;
    logic [31:0] pc2;

    trap_unit_top u_trap_unit_top (
        .clk           (clk),
        .resetn        (resetn),
        .csr_wen_i     (csr_wen_i),
        .csr_addr_i    (csr_addr_i),
        .csr_wdata_i   (csr_wdata_i),
        .csr_rdata_o   (csr_rdata_o),
        .ecall_i       (ecall_i),
        .mret_i        (mret_i),
        .pc_i          (pc_i),
        .plic_wen_i    (plic_wen_i),
        .plic_ren_i    (plic_ren_i),
        .plic_addr_i   (plic_addr_i),
        .plic_wdata_i  (plic_wdata_i),
        .plic_rdata_o  (plic_rdata_o),
        .intr_i        (intr_i),
        .trap_flush_o  (trap_flush_o),
        .trap_vector_o (trap_vector_o),
        .epc_o         (epc_o),
        .trap_cause_o  (trap_cause_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Finished with errors");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %s got 0x%08h expected 0x%08h", name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic add_row(input op_e op, input logic [31:0] addr,
                           input logic [31:0] data, input logic [31:0] expv);
        row_op[n_rows]   = op;
        row_addr[n_rows] = addr;
        row_data[n_rows] = data;
        row_exp[n_rows]  = expv;
        n_rows++;
    endtask

    // ========================================================================
    // stimulus table
    // ========================================================================

    task automatic build_table();
        // reset state and csr access
        add_row(OP_CHK_FLUSH, 0, 0, 0);
        add_row(OP_PLIC_RD, plic_pkg::PLIC_PENDING, 0, 0);
        add_row(OP_CSR_RD, trap_pkg::CSR_MTVEC, 0, `MTVEC_RESET);
        add_row(OP_CSR_WR, trap_pkg::CSR_MTVEC, vec1, 0);
        add_row(OP_CSR_RD, trap_pkg::CSR_MTVEC, 0, vec1);
        add_row(OP_CSR_WR, trap_pkg::CSR_MIE, 32'h800, 0);
        add_row(OP_CSR_RD, trap_pkg::CSR_MIE, 0, 32'h800);
        add_row(OP_CSR_WR, trap_pkg::CSR_MSTATUS, 32'h8, 0);
        add_row(OP_CSR_RD, trap_pkg::CSR_MSTATUS, 0, 32'h8);
        add_row(OP_CSR_WR, trap_pkg::CSR_MIP, 32'hFFFF_FFFF, 0);
        add_row(OP_CSR_RD, trap_pkg::CSR_MIP, 0, 0);
        // ecall gives a one-cycle flush
        add_row(OP_ECALL, 0, pc1, 0);
        add_row(OP_CHK_FLUSH, 0, 0, 1);
        add_row(OP_CHK_EPC, 0, 0, pc1);
        add_row(OP_CHK_CAUSE, 0, 0, 32'h0000_000B);
        add_row(OP_CHK_VEC, 0, 0, vec1);
        add_row(OP_CSR_RD, trap_pkg::CSR_MSTATUS, 0, 32'h80);
        add_row(OP_CHK_FLUSH, 0, 0, 0);
        // second ecall inside the handler is ignored
        add_row(OP_ECALL, 0, pc2, 0);
        add_row(OP_CHK_FLUSH, 0, 0, 0);
        add_row(OP_CHK_EPC, 0, 0, pc1);
        add_row(OP_MRET, 0, 0, 0);
        add_row(OP_CHK_FLUSH, 0, 0, 0);
        add_row(OP_CSR_RD, trap_pkg::CSR_MSTATUS, 0, 32'h88);
        // arbitration with interrupts masked
        add_row(OP_CSR_WR, trap_pkg::CSR_MSTATUS, 0, 0);
        add_row(OP_PLIC_WR, 32'h4, 2, 0);
        add_row(OP_PLIC_WR, 32'h8, 5, 0);
        add_row(OP_PLIC_WR, 32'hC, 5, 0);
        add_row(OP_PLIC_WR, 32'h10, 3, 0);
        add_row(OP_PLIC_WR, plic_pkg::PLIC_ENABLE, 32'h1A, 0);
        add_row(OP_SRC, 0, 32'h1E, 0);
        add_row(OP_PLIC_RD, plic_pkg::PLIC_PENDING, 0, 32'h1E);
        add_row(OP_PLIC_WR, plic_pkg::PLIC_THRESHOLD, 5, 0);
        add_row(OP_PLIC_RD, plic_pkg::PLIC_CLAIM, 0, 0);
        add_row(OP_CSR_RD, trap_pkg::CSR_MIP, 0, 0);
        add_row(OP_PLIC_WR, plic_pkg::PLIC_THRESHOLD, 1, 0);
        add_row(OP_CSR_RD, trap_pkg::CSR_MIP, 0, 32'h800);
        // ids 2 and 3 tie at priority 5
        add_row(OP_PLIC_WR, plic_pkg::PLIC_ENABLE, 32'h1E, 0);
        add_row(OP_PLIC_RD, plic_pkg::PLIC_CLAIM, 0, 2);
        // claim and complete
        add_row(OP_PLIC_RD, plic_pkg::PLIC_PENDING, 0, 32'h1A);
        add_row(OP_IDLE, 0, 0, 0);
        add_row(OP_PLIC_RD, plic_pkg::PLIC_PENDING, 0, 32'h1A);
        add_row(OP_PLIC_RD, plic_pkg::PLIC_CLAIM, 0, 3);
        add_row(OP_PLIC_WR, plic_pkg::PLIC_CLAIM, 2, 0);
        add_row(OP_IDLE, 0, 0, 0);
        add_row(OP_PLIC_RD, plic_pkg::PLIC_PENDING, 0, 32'h16);
        // pending line but MIE clear
        add_row(OP_CSR_RD, trap_pkg::CSR_MIP, 0, 32'h800);
        add_row(OP_IDLE, 0, 0, 0);
        add_row(OP_CHK_FLUSH, 0, 0, 0);
        // external interrupt trap from id 5
        add_row(OP_PLIC_WR, plic_pkg::PLIC_THRESHOLD, 6, 0);
        add_row(OP_PLIC_WR, 32'h14, 7, 0);
        add_row(OP_PLIC_WR, plic_pkg::PLIC_ENABLE, 32'h3E, 0);
        add_row(OP_CSR_WR, trap_pkg::CSR_MSTATUS, 32'h8, 0);
        add_row(OP_CHK_FLUSH, 0, 0, 0);
        add_row(OP_SRC, 0, 32'h3E, 0);
        add_row(OP_CHK_FLUSH, 0, 0, 0);
        add_row(OP_IDLE, 0, 0, 0);
        add_row(OP_CHK_FLUSH, 0, 0, 1);
        add_row(OP_CHK_CAUSE, 0, 0, 32'h8000_000B);
        add_row(OP_CHK_EPC, 0, 0, pc2);
        add_row(OP_CHK_VEC, 0, 0, vec1);
        add_row(OP_CSR_RD, trap_pkg::CSR_MSTATUS, 0, 32'h80);
        add_row(OP_CHK_FLUSH, 0, 0, 0);
        add_row(OP_PLIC_RD, plic_pkg::PLIC_CLAIM, 0, 5);
        add_row(OP_SRC, 0, 32'h1E, 0);
        add_row(OP_PLIC_WR, plic_pkg::PLIC_CLAIM, 5, 0);
        add_row(OP_MRET, 0, 0, 0);
        add_row(OP_CHK_FLUSH, 0, 0, 0);
        add_row(OP_CSR_RD, trap_pkg::CSR_MSTATUS, 0, 32'h88);
    endtask

    task automatic clear_strobes();
        csr_wen_i  = 1'b0;
        plic_wen_i = 1'b0;
        plic_ren_i = 1'b0;
        ecall_i    = 1'b0;
        mret_i     = 1'b0;
    endtask

    task automatic drive_inputs(input op_e op, input logic [31:0] addr,
                                input logic [31:0] data);
        case (op)
            OP_CSR_WR: begin
                csr_wen_i   = 1'b1;
                csr_addr_i  = addr[11:0];
                csr_wdata_i = data;
            end
            OP_CSR_RD:  csr_addr_i = addr[11:0];
            OP_PLIC_WR: begin
                plic_wen_i   = 1'b1;
                plic_addr_i  = addr[23:0];
                plic_wdata_i = data;
            end
            OP_PLIC_RD: begin
                plic_ren_i  = 1'b1;
                plic_addr_i = addr[23:0];
            end
            OP_ECALL: begin
                ecall_i = 1'b1;
                pc_i    = data;
            end
            OP_MRET: mret_i = 1'b1;
            OP_SRC:  intr_i = data[`PLIC_NUM_SRC-1:0];
            default: ;
        endcase
    endtask

    // check rows sample in place and other rows take one cycle
    task automatic apply_row(input int idx);
        op_e op;
        op = row_op[idx];
        case (op)
            OP_CHK_FLUSH: check_value("trap_flush_o", {31'b0, trap_flush_o}, row_exp[idx]);
            OP_CHK_EPC:   check_value("epc_o", epc_o, row_exp[idx]);
            OP_CHK_CAUSE: check_value("trap_cause_o", trap_cause_o, row_exp[idx]);
            OP_CHK_VEC:   check_value("trap_vector_o", trap_vector_o, row_exp[idx]);
            default: begin
                drive_inputs(op, row_addr[idx], row_data[idx]);
                #1;
                if (op == OP_CSR_RD) begin
                    check_value("csr_rdata_o", csr_rdata_o, row_exp[idx]);
                end
                if (op == OP_PLIC_RD) begin
                    check_value("plic_rdata_o", plic_rdata_o, row_exp[idx]);
                end
                @(posedge clk);
                @(negedge clk);
                clear_strobes();
            end
        endcase
    endtask

    // ========================================================================
    // main sequence
    // ========================================================================

    initial begin
        clk          = 1'b0;
        resetn       = 1'b0;
        csr_addr_i   = '0;
        csr_wdata_i  = '0;
        pc_i         = '0;
        plic_addr_i  = '0;
        plic_wdata_i = '0;
        intr_i       = '0;
        clear_strobes();
        n_rows       = 0;
        error_count  = 0;
        cycle_count  = 0;
        void'($urandom(16592));
        vec1         = $urandom() & 32'hFFFF_FFFC;
        pc1          = $urandom() & 32'hFFFF_FFFC;
        pc2          = $urandom() & 32'hFFFF_FFFC;
        build_table();
        cycle_limit  = n_rows * 4 + 50;
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            apply_row(i);
        end
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+hw
hw/trap_pkg.sv
hw/plic_pkg.sv
hw/trap_if.sv
hw/plic_gw_if.sv
hw/plic_gateway.sv
hw/plic_arbiter.sv
hw/csr_file.sv
hw/trap_ctrl.sv
hw/trap_unit_top.sv
dv/tb_trap_unit.sv

// ==== run.sh ====
#!/bin/sh
# build and run the trap unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_trap_unit -f sim.f -o sim_tb

# a fatal stop returns nonzero, so the log decides the result
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
exit 0
